//--- tb.f
shadow_pkg.sv
apb_record_feeder.sv
step_controller.sv
shadow_stage_chain.sv
retire_port.sv
shadow_pipeline_top.sv
tb_clk_gen.sv
tb_shadow_pipeline.sv

//--- Bender.yml
package:
  name: shadow_pipeline

sources:
  - files:
      - shadow_pkg.sv
      - apb_record_feeder.sv
      - step_controller.sv
      - shadow_stage_chain.sv
      - retire_port.sv
      - shadow_pipeline_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_shadow_pipeline.sv

//--- tb_shadow_pipeline.sv
`timescale 1ns/1ps

module tb_shadow_pipeline;
    import shadow_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int PIPE_DEPTH     = 3;
    localparam int PRIME          = PIPE_DEPTH - 1;
    localparam int N_REC          = 12;
    localparam int TIMEOUT_CYCLES = 40 * N_REC + 100;

    // Each entry is {insn, pc}. The expected order of an entry is its index.
    localparam logic [63:0] REC_TAB [N_REC] = '{
        64'h00500093_80000000, 64'h00a00113_80000004, 64'h002081b3_80000008,
        64'h40110233_8000000c, 64'h0041a2b3_80000010, 64'h00128313_80000014,
        64'h0062a023_80000018, 64'h0002a383_8000001c, 64'hfe731ee3_80000020,
        64'h00c000ef_80000024, 64'h00008067_80000028, 64'h00000013_8000002c
    };

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic              core_retire;
    logic [DATA_W-1:0] irq;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              trace_valid;
    logic [DATA_W-1:0] trace_insn;
    logic [DATA_W-1:0] trace_pc;
    logic [ORDER_W-1:0] trace_order;
    logic              irq_event;
    logic [DATA_W-1:0] irq_value;
    logic              desync;
    logic [DATA_W-1:0] irq_new;
    int                pushed;
    int                cycles = 0;

    tb_clk_gen clk_gen0 (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    shadow_pipeline_top dut0 (
        .clk (clk), .rst_n (rst_n),
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
        .paddr_i (paddr), .pwdata_i (pwdata),
        .core_retire_i (core_retire), .irq_i (irq),
        .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .trace_valid_o (trace_valid), .trace_insn_o (trace_insn),
        .trace_pc_o (trace_pc), .trace_order_o (trace_order),
        .irq_event_o (irq_event), .irq_value_o (irq_value), .desync_o (desync)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive point, just after the edge.
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Expected REG_STATUS word for a given fill level.
    function automatic logic [31:0] status_word(input int level);
        return {22'b0, level == 0, level == FIFO_DEPTH, 8'(level)};
    endfunction

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic err, input string name);
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        #2;
        check({name, " pslverr"}, err, pslverr);
        check({name, " pready"}, 1'b1, pready);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [31:0] expected,
                            input string name);
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        #2;
        check(name, expected, prdata);
        check({name, " pslverr"}, 1'b0, pslverr);
        check({name, " pready"}, 1'b1, pready);
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic push_record(input int idx);
        apb_write(REG_INSN, REC_TAB[idx][63:32], 1'b0, "insn write");
        apb_write(REG_PC, REC_TAB[idx][31:0], 1'b0, "pc write");
        apb_write(REG_PUSH, 32'h0, 1'b0, "push");
    endtask

    task automatic idle_cycles(input int n, input logic exp_desync);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            #2;
            check("trace_valid when idle", 1'b0, trace_valid);
            check("desync when idle", exp_desync, desync);
        end
    endtask

    // Leaves the caller in the cycle after the strobe.
    task automatic strobe_retire();
        next_cycle();
        core_retire = 1'b1;
        next_cycle();
        core_retire = 1'b0;
        #2;
    endtask

    initial begin
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        core_retire = 1'b0;
        irq         = '0;
        void'($urandom(32'h7726));
        @(posedge rst_n);
        #2;
        check("reset trace_valid", 1'b0, trace_valid);
        check("reset irq_event", 1'b0, irq_event);
        check("reset desync", 1'b0, desync);
        check("reset pslverr", 1'b0, pslverr);
        apb_read(REG_STATUS, status_word(0), "status after reset");

        apb_write(REG_INSN, 32'hcafe0001, 1'b0, "insn write");
        apb_write(REG_PC, 32'h00001234, 1'b0, "pc write");
        apb_read(REG_INSN, 32'hcafe0001, "insn readback");
        apb_read(REG_PC, 32'h00001234, "pc readback");
        apb_read(REG_PUSH, 32'h0, "push readback");
        apb_write(4'h2, 32'h0, 1'b1, "unmapped write");

        // The first PRIME records are taken by the chain at once.
        for (int i = 0; i < PRIME + FIFO_DEPTH; i++) begin
            push_record(i);
            apb_read(REG_STATUS, status_word((i < PRIME) ? 0 : i - PRIME + 1),
                     "status after push");
        end
        apb_write(REG_PUSH, 32'h0, 1'b1, "push when full");
        apb_read(REG_STATUS, status_word(FIFO_DEPTH), "status after refused push");
        idle_cycles(4, 1'b0);

        pushed = PRIME + FIFO_DEPTH;
        for (int k = 0; k < N_REC; k++) begin
            if (pushed < N_REC && pushed - (k + PRIME) < FIFO_DEPTH) begin
                push_record(pushed);
                pushed++;
            end
            strobe_retire();
            check("trace_valid", 1'b1, trace_valid);
            check("trace_insn", REC_TAB[k][63:32], trace_insn);
            check("trace_pc", REC_TAB[k][31:0], trace_pc);
            check("trace_order", k, trace_order);
            check("desync while tracking", 1'b0, desync);
            idle_cycles($urandom % 4, 1'b0);
        end

        for (int r = 0; r < 4; r++) begin
            irq_new = $urandom;
            if (irq_new == irq) begin
                irq_new = ~irq;
            end
            next_cycle();
            irq = irq_new;
            next_cycle();
            #2;
            check("irq_event on change", 1'b1, irq_event);
            check("irq_value", irq_new, irq_value);
            next_cycle();
            #2;
            check("irq_event when steady", 1'b0, irq_event);
        end

        // The queue is drained, so the next retire meets a bubble.
        strobe_retire();
        check("trace_valid on bubble", 1'b0, trace_valid);
        check("desync after bubble", 1'b1, desync);
        idle_cycles(3, 1'b1);

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset is released just after an edge, like every other input.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- shadow_pipeline_top.sv
`timescale 1ns/1ps

module shadow_pipeline_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int PIPE_DEPTH = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [shadow_pkg::ADDR_W-1:0]  paddr_i,
    input  logic [shadow_pkg::DATA_W-1:0]  pwdata_i,
    input  logic                           core_retire_i,
    input  logic [shadow_pkg::DATA_W-1:0]  irq_i,
    output logic [shadow_pkg::DATA_W-1:0]  prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    output logic                           trace_valid_o,
    output logic [shadow_pkg::DATA_W-1:0]  trace_insn_o,
    output logic [shadow_pkg::DATA_W-1:0]  trace_pc_o,
    output logic [shadow_pkg::ORDER_W-1:0] trace_order_o,
    output logic                           irq_event_o,
    output logic [shadow_pkg::DATA_W-1:0]  irq_value_o,
    output logic                           desync_o
);
    import shadow_pkg::*;

    logic               rec_valid;
    logic [DATA_W-1:0]  rec_insn;
    logic [DATA_W-1:0]  rec_pc;
    logic [ORDER_W-1:0] rec_order;
    logic               pop;
    logic               step;
    logic               ex_valid;
    logic [DATA_W-1:0]  ex_insn;
    logic [DATA_W-1:0]  ex_pc;
    logic [ORDER_W-1:0] ex_order;

    apb_record_feeder #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) feeder0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .pop_i       (pop),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .rec_valid_o (rec_valid),
        .rec_insn_o  (rec_insn),
        .rec_pc_o    (rec_pc),
        .rec_order_o (rec_order)
    );

    step_controller #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) ctrl0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .rec_valid_i   (rec_valid),
        .core_retire_i (core_retire_i),
        .step_o        (step)
    );

    shadow_stage_chain #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) chain0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .step_i      (step),
        .rec_valid_i (rec_valid),
        .rec_insn_i  (rec_insn),
        .rec_pc_i    (rec_pc),
        .rec_order_i (rec_order),
        .pop_o       (pop),
        .ex_valid_o  (ex_valid),
        .ex_insn_o   (ex_insn),
        .ex_pc_o     (ex_pc),
        .ex_order_o  (ex_order)
    );

    retire_port port0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_retire_i (core_retire_i),
        .ex_valid_i    (ex_valid),
        .ex_insn_i     (ex_insn),
        .ex_pc_i       (ex_pc),
        .ex_order_i    (ex_order),
        .irq_i         (irq_i),
        .trace_valid_o (trace_valid_o),
        .trace_insn_o  (trace_insn_o),
        .trace_pc_o    (trace_pc_o),
        .trace_order_o (trace_order_o),
        .irq_event_o   (irq_event_o),
        .irq_value_o   (irq_value_o),
        .desync_o      (desync_o)
    );

endmodule

//--- retire_port.sv
`timescale 1ns/1ps

module retire_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           core_retire_i,
    input  logic                           ex_valid_i,
    input  logic [shadow_pkg::DATA_W-1:0]  ex_insn_i,
    input  logic [shadow_pkg::DATA_W-1:0]  ex_pc_i,
    input  logic [shadow_pkg::ORDER_W-1:0] ex_order_i,
    input  logic [shadow_pkg::DATA_W-1:0]  irq_i,
    output logic                           trace_valid_o,
    output logic [shadow_pkg::DATA_W-1:0]  trace_insn_o,
    output logic [shadow_pkg::DATA_W-1:0]  trace_pc_o,
    output logic [shadow_pkg::ORDER_W-1:0] trace_order_o,
    output logic                           irq_event_o,
    output logic [shadow_pkg::DATA_W-1:0]  irq_value_o,
    output logic                           desync_o
);
    import shadow_pkg::*;

    logic [DATA_W-1:0] irq_q;
    logic              irq_event_q;
    logic              retire_q;
    logic              desync_q;
    logic              miss;

    // The last stage already pulses for one cycle per step.
    assign trace_valid_o = ex_valid_i;
    assign trace_insn_o  = ex_insn_i;
    assign trace_pc_o    = ex_pc_i;
    assign trace_order_o = ex_order_i;

    // A retire with no record behind it means the shadow has fallen behind.
    assign miss = retire_q & ~ex_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q       <= '0;
            irq_event_q <= 1'b0;
            retire_q    <= 1'b0;
            desync_q    <= 1'b0;
        end else begin
            irq_q       <= irq_i;
            irq_event_q <= (irq_i != irq_q);
            retire_q    <= core_retire_i;
            desync_q    <= desync_q | miss;  // Sticky until reset.
        end
    end

    assign irq_event_o = irq_event_q;
    assign irq_value_o = irq_q;  // Holds the value sampled on the change edge.
    assign desync_o    = desync_q | miss;

endmodule

//--- shadow_stage_chain.sv
`timescale 1ns/1ps

module shadow_stage_chain #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           step_i,
    input  logic                           rec_valid_i,
    input  logic [shadow_pkg::DATA_W-1:0]  rec_insn_i,
    input  logic [shadow_pkg::DATA_W-1:0]  rec_pc_i,
    input  logic [shadow_pkg::ORDER_W-1:0] rec_order_i,
    output logic                           pop_o,
    output logic                           ex_valid_o,
    output logic [shadow_pkg::DATA_W-1:0]  ex_insn_o,
    output logic [shadow_pkg::DATA_W-1:0]  ex_pc_o,
    output logic [shadow_pkg::ORDER_W-1:0] ex_order_o
);
    import shadow_pkg::*;

    localparam int LAST = PIPE_DEPTH - 1;

    logic [PIPE_DEPTH-1:0] valid_q;
    logic [DATA_W-1:0]     insn_q [PIPE_DEPTH];
    logic [DATA_W-1:0]     pc_q [PIPE_DEPTH];
    logic [ORDER_W-1:0]    order_q [PIPE_DEPTH];

    assign pop_o = step_i & rec_valid_i;  // Head is consumed by the first stage.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (step_i) begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], rec_valid_i};
        end else begin
            valid_q[LAST] <= 1'b0;  // Report each record for one cycle only.
        end
    end

    always_ff @(posedge clk) begin
        if (step_i) begin
            insn_q[0]  <= rec_insn_i;
            pc_q[0]    <= rec_pc_i;
            order_q[0] <= rec_order_i;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                insn_q[i]  <= insn_q[i-1];
                pc_q[i]    <= pc_q[i-1];
                order_q[i] <= order_q[i-1];
            end
        end
    end

    assign ex_valid_o = valid_q[LAST];
    assign ex_insn_o  = insn_q[LAST];
    assign ex_pc_o    = pc_q[LAST];
    assign ex_order_o = order_q[LAST];

endmodule

//--- step_controller.sv
`timescale 1ns/1ps

module step_controller #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rec_valid_i,
    input  logic core_retire_i,
    output logic step_o
);
    import shadow_pkg::*;

    localparam int PRIME = PIPE_DEPTH - 1;
    localparam int CNT_W = (PIPE_DEPTH > 2) ? $clog2(PIPE_DEPTH) : 1;

    ctrl_state_e      state_q;
    logic [CNT_W-1:0] prime_q;

    always_comb begin
        if (state_q == ST_FILL) begin
            step_o = rec_valid_i;  // Prime whenever a record is available.
        end else begin
            step_o = core_retire_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_FILL;
            prime_q <= '0;
        end else if (state_q == ST_FILL && step_o) begin
            if (prime_q == CNT_W'(PRIME - 1)) begin
                state_q <= ST_TRACK;  // Chain now sits in phase with the core.
            end else begin
                prime_q <= prime_q + 1'b1;
            end
        end
    end

endmodule

//--- apb_record_feeder.sv
`timescale 1ns/1ps

module apb_record_feeder #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [shadow_pkg::ADDR_W-1:0]  paddr_i,
    input  logic [shadow_pkg::DATA_W-1:0]  pwdata_i,
    input  logic                        pop_i,
    output logic [shadow_pkg::DATA_W-1:0]  prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        rec_valid_o,
    output logic [shadow_pkg::DATA_W-1:0]  rec_insn_o,
    output logic [shadow_pkg::DATA_W-1:0]  rec_pc_o,
    output logic [shadow_pkg::ORDER_W-1:0] rec_order_o
);
    import shadow_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0]  stage_insn_q;
    logic [DATA_W-1:0]  stage_pc_q;
    logic [DATA_W-1:0]  mem_insn [FIFO_DEPTH];
    logic [DATA_W-1:0]  mem_pc [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   fill_q;
    logic [ORDER_W-1:0] order_q;
    logic               access;
    logic               reg_hit;
    logic               full;
    logic               empty;
    logic               push_req;
    logic               push_ok;
    logic [DATA_W-1:0]  status;

    assign access   = psel_i & penable_i;  // APB access phase.
    assign full     = (fill_q == CNT_W'(FIFO_DEPTH));
    assign empty    = (fill_q == '0);
    assign push_req = access & pwrite_i & (paddr_i == REG_PUSH);
    assign push_ok  = push_req & ~full;

    assign status = {{(DATA_W - STATUS_EMPTY - 1){1'b0}}, empty, full,
                     STATUS_LEVEL_W'(fill_q)};

    // Read mux and address decode.
    always_comb begin
        reg_hit  = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_INSN:   prdata_o = stage_insn_q;
            REG_PC:     prdata_o = stage_pc_q;
            REG_PUSH:   prdata_o = '0;
            REG_STATUS: prdata_o = status;
            default:    reg_hit  = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~reg_hit | (push_req & full) |
                                 (pwrite_i & (paddr_i == REG_STATUS)));

    always_ff @(posedge clk) begin
        if (access && pwrite_i && paddr_i == REG_INSN) begin
            stage_insn_q <= pwdata_i;
        end
        if (access && pwrite_i && paddr_i == REG_PC) begin
            stage_pc_q <= pwdata_i;
        end
        if (push_ok) begin
            mem_insn[wr_ptr_q] <= stage_insn_q;
            mem_pc[wr_ptr_q]   <= stage_pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            order_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
                order_q  <= order_q + 1'b1;  // Next record gets the next number.
            end
            if (push_ok && !pop_i) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop_i && !push_ok) begin
                fill_q <= fill_q - 1'b1;
            end
        end
    end

    assign rec_valid_o = ~empty;
    assign rec_insn_o  = mem_insn[rd_ptr_q];
    assign rec_pc_o    = mem_pc[rd_ptr_q];
    assign rec_order_o = order_q;

endmodule

//--- shadow_pkg.sv
package shadow_pkg;

    // Instruction word, program counter and APB data all share one width.
    parameter int DATA_W  = 32;
    parameter int ORDER_W = 16;
    parameter int ADDR_W  = 4;

    // APB register offsets of the record feeder.
    typedef enum logic [ADDR_W-1:0] {
        REG_INSN   = 4'h0,
        REG_PC     = 4'h4,
        REG_PUSH   = 4'h8,
        REG_STATUS = 4'hC
    } apb_reg_e;

    // Bit positions inside REG_STATUS.
    parameter int STATUS_LEVEL_W = 8;
    parameter int STATUS_FULL    = 8;
    parameter int STATUS_EMPTY   = 9;

    // The chain is primed first, then it follows the core.
    typedef enum logic {
        ST_FILL,
        ST_TRACK
    } ctrl_state_e;

endpackage
